/* source/npu_pkg.sv */
`default_nettype none

package npu_pkg;

    // array geometry
    localparam int NPU_IN_NUM   = 4;
    localparam int NPU_OUT_NUM  = 4;

    // datapath widths
    localparam int DATA_WIDTH   = 8;
    localparam int WEIGHT_WIDTH = 8;
    localparam int BIAS_WIDTH   = 16;
    localparam int ACC_WIDTH    = 24;
    localparam int SCALE_WIDTH  = 4;

    // skew 1, chain NPU_IN_NUM, accumulator 1, requant 2
    localparam int CORE_LATENCY = NPU_IN_NUM + 4;

    typedef logic signed [DATA_WIDTH-1:0]   npu_act_t;
    typedef logic signed [WEIGHT_WIDTH-1:0] npu_weight_t;
    typedef logic signed [BIAS_WIDTH-1:0]   npu_bias_t;
    typedef logic signed [ACC_WIDTH-1:0]    npu_sum_t;

    typedef npu_act_t    [NPU_IN_NUM-1:0]                  npu_lanes_t;
    typedef npu_weight_t [NPU_OUT_NUM-1:0][NPU_IN_NUM-1:0] npu_weights_t;
    typedef npu_bias_t   [NPU_OUT_NUM-1:0]                 npu_biases_t;
    typedef npu_act_t    [NPU_OUT_NUM-1:0]                 npu_outputs_t;

    typedef struct packed {
        logic       valid;
        logic       first;
        npu_lanes_t lanes;
    } npu_sample_t;

    // one chain result or accumulator value
    typedef struct packed {
        logic     valid;
        npu_sum_t acc;
    } npu_acc_t;

endpackage

`default_nettype wire

/* source/npu_input_skew.sv */
`timescale 1ns/1ps
`default_nettype none

module npu_input_skew (
    input  logic                clk,
    input  logic                rstn,
    input  npu_pkg::npu_lanes_t data_in,
    input  logic                data_valid,
    input  logic                acc_first,
    output npu_pkg::npu_sample_t sample
);
    import npu_pkg::*;

    npu_sample_t in_q;
    logic        valid_q;
    logic        first_q;
    npu_lanes_t  skew_lanes;

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            in_q    <= '0;
            valid_q <= 1'b0;
            first_q <= 1'b0;
        end
        else
        begin
            in_q    <= '{valid: data_valid, first: acc_first, lanes: data_in};
            // flags stay aligned with lane 0
            valid_q <= in_q.valid;
            first_q <= in_q.first;
        end
    end

    // triangular delay, lane k gets k+1 registers
    for (genvar k = 0; k < NPU_IN_NUM; k++)
    begin : g_lane
        npu_act_t dly [0:k];

        always_ff @(posedge clk or negedge rstn)
        begin
            if (!rstn)
            begin
                for (int i = 0; i <= k; i++)
                begin
                    dly[i] <= '0;
                end
            end
            else
            begin
                dly[0] <= in_q.lanes[k];
                for (int i = 1; i <= k; i++)
                begin
                    dly[i] <= dly[i-1];
                end
            end
        end

        assign skew_lanes[k] = dly[k];
    end

    assign sample = '{valid: valid_q, first: first_q, lanes: skew_lanes};

endmodule

`default_nettype wire

/* source/npu_neuron.sv */
`timescale 1ns/1ps
`default_nettype none

module npu_neuron (
    input  logic                                 clk,
    input  logic                                 rstn,
    input  npu_pkg::npu_sample_t                 sample,
    input  npu_pkg::npu_lanes_t                  weight_row,
    input  logic                                 weight_load,
    input  logic signed [npu_pkg::BIAS_WIDTH-1:0] bias,
    input  logic                                 bias_load,
    output npu_pkg::npu_acc_t                    result
);
    import npu_pkg::*;

    npu_lanes_t            weight_q;
    npu_bias_t             bias_q;
    npu_sum_t              psum [NPU_IN_NUM];
    logic [NPU_IN_NUM-1:0] vld;
    logic [NPU_IN_NUM-1:0] fst;

    // one multiply-add step, wraps at ACC_WIDTH
    function automatic npu_sum_t mac(
        input npu_sum_t base,
        input npu_act_t act,
        input npu_act_t wgt
    );
        return base + $signed(act) * $signed(wgt);
    endfunction

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            weight_q <= '0;
            bias_q   <= '0;
        end
        else
        begin
            if (weight_load)
            begin
                weight_q <= weight_row;
            end
            if (bias_load)
            begin
                bias_q <= bias;
            end
        end
    end

    // chain, stage k sees lane k one cycle after stage k-1
    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            vld <= '0;
            fst <= '0;
            for (int k = 0; k < NPU_IN_NUM; k++)
            begin
                psum[k] <= '0;
            end
        end
        else
        begin
            vld[0]  <= sample.valid;
            fst[0]  <= sample.first;
            psum[0] <= mac(npu_sum_t'(bias_q), sample.lanes[0], weight_q[0]);
            for (int k = 1; k < NPU_IN_NUM; k++)
            begin
                vld[k]  <= vld[k-1];
                fst[k]  <= fst[k-1];
                psum[k] <= mac(psum[k-1], sample.lanes[k], weight_q[k]);
            end
        end
    end

    // running sum across samples
    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            result <= '0;
        end
        else
        begin
            result.valid <= vld[NPU_IN_NUM-1];
            if (vld[NPU_IN_NUM-1])
            begin
                if (fst[NPU_IN_NUM-1])
                    result.acc <= psum[NPU_IN_NUM-1];
                else
                    result.acc <= result.acc + psum[NPU_IN_NUM-1];
            end
        end
    end

endmodule

`default_nettype wire

/* source/npu_requant.sv */
`timescale 1ns/1ps
`default_nettype none

module npu_requant (
    input  logic                           clk,
    input  logic                           rstn,
    input  npu_pkg::npu_acc_t              acc_in [npu_pkg::NPU_OUT_NUM],
    input  logic [npu_pkg::SCALE_WIDTH-1:0] scale,
    output npu_pkg::npu_outputs_t          data_out,
    output logic                           data_out_valid
);
    import npu_pkg::*;

    npu_sum_t shift_q [NPU_OUT_NUM];
    logic     shift_vld;

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            shift_vld <= 1'b0;
            for (int o = 0; o < NPU_OUT_NUM; o++)
            begin
                shift_q[o] <= '0;
            end
        end
        else
        begin
            // neurons run in lockstep, neuron 0 speaks for all
            shift_vld <= acc_in[0].valid;
            if (acc_in[0].valid)
            begin
                for (int o = 0; o < NPU_OUT_NUM; o++)
                begin
                    shift_q[o] <= acc_in[o].acc >>> scale;
                end
            end
        end
    end

    // clamp to int8
    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            data_out       <= '0;
            data_out_valid <= 1'b0;
        end
        else
        begin
            data_out_valid <= shift_vld;
            if (shift_vld)
            begin
                for (int o = 0; o < NPU_OUT_NUM; o++)
                begin
                    if (shift_q[o] > 127)
                        data_out[o] <= {1'b0, {(DATA_WIDTH-1){1'b1}}};
                    else if (shift_q[o] < -128)
                        data_out[o] <= {1'b1, {(DATA_WIDTH-1){1'b0}}};
                    else
                        data_out[o] <= shift_q[o][DATA_WIDTH-1:0];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* source/npu_core.sv */
`timescale 1ns/1ps
`default_nettype none

module npu_core (
    input  logic                           clk,
    input  logic                           rstn,

    input  npu_pkg::npu_lanes_t            data_in,
    input  logic                           data_valid,
    input  logic                           acc_first,

    input  npu_pkg::npu_weights_t          weight_in,
    input  logic                           weight_load,

    input  npu_pkg::npu_biases_t           bias_in,
    input  logic                           bias_load,

    input  logic [npu_pkg::SCALE_WIDTH-1:0] scale,

    output npu_pkg::npu_outputs_t          data_out,
    output logic                           data_out_valid
);
    import npu_pkg::*;

    npu_sample_t sample;
    npu_acc_t    neuron_acc [NPU_OUT_NUM];

    // lane k reaches chain stage k on time
    npu_input_skew u_skew (
        .clk        (clk),
        .rstn       (rstn),
        .data_in    (data_in),
        .data_valid (data_valid),
        .acc_first  (acc_first),
        .sample     (sample)
    );

    // one chain per output neuron, all share the skewed sample
    for (genvar o = 0; o < NPU_OUT_NUM; o++)
    begin : g_neuron
        npu_neuron u_neuron (
            .clk         (clk),
            .rstn        (rstn),
            .sample      (sample),
            .weight_row  (weight_in[o]),
            .weight_load (weight_load),
            .bias        (bias_in[o]),
            .bias_load   (bias_load),
            .result      (neuron_acc[o])
        );
    end

    npu_requant u_requant (
        .clk            (clk),
        .rstn           (rstn),
        .acc_in         (neuron_acc),
        .scale          (scale),
        .data_out       (data_out),
        .data_out_valid (data_out_valid)
    );

endmodule

`default_nettype wire

/* dv/npu_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module npu_core_tb;
    import npu_pkg::*;

    logic                   clk = 1'b0;
    logic                   rstn;
    npu_lanes_t             data_in;
    logic                   data_valid;
    logic                   acc_first;
    npu_weights_t           weight_in;
    logic                   weight_load;
    npu_biases_t            bias_in;
    logic                   bias_load;
    logic [SCALE_WIDTH-1:0] scale;
    npu_outputs_t           data_out;
    logic                   data_out_valid;

    // model state
    logic [31:0]            lfsr = 32'h614d_555f;
    npu_weights_t           tb_w = '0;
    npu_biases_t            tb_b = '0;
    npu_sum_t               tb_acc [NPU_OUT_NUM] = '{default: '0};
    logic [SCALE_WIDTH-1:0] tb_scale = '0;
    npu_outputs_t           exp_q [$];
    int                     due_q [$];
    int                     cyc = 0;
    int                     sent_count = 0;

    // captured on the falling edge and held across the next rising edge
    npu_outputs_t           chk_got = '0;
    npu_outputs_t           chk_expect = '0;
    logic                   chk_valid = 1'b0;
    logic                   chk_queued = 1'b0;
    logic                   chk_on_time = 1'b0;
    logic                   chk_idle = 1'b1;

    npu_core dut (
        .clk            (clk),
        .rstn           (rstn),
        .data_in        (data_in),
        .data_valid     (data_valid),
        .acc_first      (acc_first),
        .weight_in      (weight_in),
        .weight_load    (weight_load),
        .bias_in        (bias_in),
        .bias_load      (bias_load),
        .scale          (scale),
        .data_out       (data_out),
        .data_out_valid (data_out_valid)
    );

    always #10 clk = ~clk;

    always @(posedge clk)
    begin
        cyc <= cyc + 1;
    end

    // galois lfsr stepped once per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic int rand_signed(input int n);
        int v;
        v = int'(take_bits(n));
        if (v >= (1 << (n - 1)))
            v = v - (1 << n);
        return v;
    endfunction

    function automatic npu_lanes_t random_lanes(input int nbits);
        npu_lanes_t l;
        for (int k = 0; k < NPU_IN_NUM; k++)
        begin
            l[k] = DATA_WIDTH'(rand_signed(nbits));
        end
        return l;
    endfunction

    // bias plus dot product, accumulate, shift, clamp
    function automatic npu_outputs_t predict(input npu_lanes_t lanes, input logic first);
        npu_outputs_t res;
        int           sum;
        int           shifted;
        for (int o = 0; o < NPU_OUT_NUM; o++)
        begin
            sum = int'(tb_b[o]);
            for (int k = 0; k < NPU_IN_NUM; k++)
            begin
                sum += int'(tb_w[o][k]) * int'(lanes[k]);
            end
            if (first)
                tb_acc[o] = ACC_WIDTH'(sum);
            else
                tb_acc[o] = tb_acc[o] + ACC_WIDTH'(sum);
            shifted = int'(tb_acc[o]) >>> tb_scale;
            if (shifted > 127)
                shifted = 127;
            else if (shifted < -128)
                shifted = -128;
            res[o] = DATA_WIDTH'(shifted);
        end
        return res;
    endfunction

    task automatic fail_with(input string msg);
        $display("%0t: %s", $time, msg);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic report_mismatch(input npu_outputs_t got, input npu_outputs_t exp);
        int lane;
        lane = 0;
        for (int o = NPU_OUT_NUM - 1; o >= 0; o--)
        begin
            if (got[o] != exp[o])
                lane = o;
        end
        $display("MISMATCH at %0t: output lane %0d is %0d, expected %0d",
                 $time, lane, got[lane], exp[lane]);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic send_sample(input npu_lanes_t lanes, input logic first);
        @(posedge clk);
        data_in    <= lanes;
        data_valid <= 1'b1;
        acc_first  <= first;
        exp_q.push_back(predict(lanes, first));
        // the sampling edge is two counts ahead of cyc
        due_q.push_back(cyc + CORE_LATENCY + 2);
        sent_count++;
    endtask

    task automatic end_burst();
        @(posedge clk);
        data_valid <= 1'b0;
        acc_first  <= 1'b0;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_q.size() > 0 && waited < 4 * CORE_LATENCY)
        begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() > 0)
            fail_with("timeout waiting for pending results");
    endtask

    task automatic load_params(input npu_weights_t w, input npu_biases_t b);
        @(posedge clk);
        weight_in   <= w;
        bias_in     <= b;
        weight_load <= 1'b1;
        bias_load   <= 1'b1;
        @(posedge clk);
        weight_load <= 1'b0;
        bias_load   <= 1'b0;
        tb_w = w;
        tb_b = b;
    endtask

    task automatic random_params(input int wbits, input int bbits);
        npu_weights_t w;
        npu_biases_t  b;
        for (int o = 0; o < NPU_OUT_NUM; o++)
        begin
            for (int k = 0; k < NPU_IN_NUM; k++)
            begin
                w[o][k] = WEIGHT_WIDTH'(rand_signed(wbits));
            end
            b[o] = BIAS_WIDTH'(rand_signed(bbits));
        end
        load_params(w, b);
    endtask

    task automatic set_scale(input logic [SCALE_WIDTH-1:0] s);
        @(posedge clk);
        scale <= s;
        tb_scale = s;
    endtask

    always @(negedge clk)
    begin
        chk_got     = data_out;
        chk_valid   = data_out_valid;
        chk_idle    = (sent_count == 0);
        chk_queued  = 1'b0;
        chk_on_time = 1'b0;
        if (data_out_valid && exp_q.size() > 0)
        begin
            chk_queued  = 1'b1;
            chk_expect  = exp_q.pop_front();
            chk_on_time = (due_q.pop_front() == cyc);
        end
    end

    idle_valid: assert property (@(posedge clk) disable iff (!rstn)
        chk_idle |-> !chk_valid)
        else fail_with("data_out_valid high before any sample");

    idle_zero: assert property (@(posedge clk) disable iff (!rstn)
        chk_idle |-> chk_got == '0)
        else report_mismatch(chk_got, '0);

    no_extra: assert property (@(posedge clk) disable iff (!rstn)
        chk_valid |-> chk_queued)
        else fail_with("data_out_valid with no sample pending");

    on_time: assert property (@(posedge clk) disable iff (!rstn)
        chk_queued |-> chk_on_time)
        else fail_with("data_out_valid at the wrong cycle");

    values: assert property (@(posedge clk) disable iff (!rstn)
        chk_queued |-> chk_got == chk_expect)
        else report_mismatch(chk_got, chk_expect);

    initial
    begin
        npu_weights_t w;
        npu_biases_t  b;
        npu_lanes_t   lanes;
        rstn        = 1'b0;
        data_in     = '0;
        data_valid  = 1'b0;
        acc_first   = 1'b0;
        weight_in   = '0;
        weight_load = 1'b0;
        bias_in     = '0;
        bias_load   = 1'b0;
        scale       = '0;
        repeat (2) @(posedge clk);
        rstn <= 1'b1;
        repeat (6) @(posedge clk);

        // exact small dot product at scale 0
        random_params(3, 4);
        set_scale('0);
        send_sample(random_lanes(3), 1'b1);
        end_burst();
        drain();

        // clamping at, beyond and just inside the int8 limits
        w = '0;
        b = '0;
        for (int k = 0; k < NPU_IN_NUM; k++)
        begin
            w[0][k] = 8'sd127;
            w[1][k] = 8'h80;
        end
        b[2] = 16'sd127;
        b[3] = -16'sd128;
        load_params(w, b);
        lanes = {NPU_IN_NUM{8'h7f}};
        send_sample(lanes, 1'b1);
        end_burst();
        drain();
        w = '0;
        b[0] = 16'sd128;
        b[1] = -16'sd129;
        b[2] = 16'sd126;
        b[3] = -16'sd127;
        load_params(w, b);
        send_sample(lanes, 1'b1);
        end_burst();
        drain();

        // random scales on full range sums
        random_params(8, 16);
        for (int i = 0; i < 16; i++)
        begin
            set_scale(SCALE_WIDTH'(take_bits(SCALE_WIDTH)));
            send_sample(random_lanes(8), 1'b1);
            end_burst();
            drain();
        end

        // two back-to-back accumulation bursts
        set_scale(4'd6);
        for (int i = 0; i < 12; i++)
        begin
            send_sample(random_lanes(8), i == 0);
        end
        for (int i = 0; i < 8; i++)
        begin
            send_sample(random_lanes(8), i == 0);
        end
        end_burst();
        drain();

        // reload while idle
        random_params(8, 16);
        set_scale(4'd5);
        for (int i = 0; i < 4; i++)
        begin
            send_sample(random_lanes(8), i == 0);
        end
        end_burst();
        drain();
        random_params(5, 10);
        for (int i = 0; i < 3; i++)
        begin
            send_sample(random_lanes(6), i == 0);
        end
        end_burst();
        drain();

        repeat (4) @(posedge clk);
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

/* npu_core.f */
source/npu_pkg.sv
source/npu_input_skew.sv
source/npu_neuron.sv
source/npu_requant.sv
source/npu_core.sv
dv/npu_core_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := npu_core_tb
FILELIST   := npu_core.f
BUILD_DIR  := obj_dir
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert --Mdir $(BUILD_DIR)
PASS_MSG   := No errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
